//--- hw/fpu_consts.svh
// Single-precision constants; the queue depth must stay a power of two or above one entry
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// Exponent bias of binary32
`define FP_BIAS 127

// Recurrence steps, 24 root bits plus guard and round
`define SQRT_ITERS 26

// Entries of the operand queue
`define OPQ_DEPTH 4

// Quiet NaN returned for invalid or NaN inputs
`define FP_CANON_NAN 32'h7fc00000

`endif

//--- hw/fpuPkg.sv
// Shared FPU types; the class encoding assumes RISC-V fclass grouping, with rounding codes 5-7 reserved
package fpuPkg;

        // One-hot operand class, most significant group first as in fclass
        typedef struct packed {
                logic qNan;
                logic sNan;
                logic inf;
                logic normal;
                logic subnormal;
                logic zero;
        } fpClass_t;

        // RISC-V static rounding mode encodings
        typedef enum logic [2:0] {
                RNE = 3'b000,
                RTZ = 3'b001,
                RDN = 3'b010,
                RUP = 3'b011,
                RMM = 3'b100
        } roundMode_t;

        // Operand after classification and normalization
        typedef struct packed {
                // Original IEEE word, kept for sign and special results
                logic [31:0]       raw;
                fpClass_t          cls;
                // Unbiased exponent, already lowered for subnormals
                logic signed [9:0] exp;
                // Significand with the leading one at bit 23
                logic [23:0]       sig;
                roundMode_t        rm;
        } unpackedOp_t;

endpackage

//--- hw/fpRound.sv
// Combinational rounder for a positive root only; RDN truncates and RUP rounds away from zero
`timescale 1ns/1ps

module fpRound import fpuPkg::*; (
        input  logic [25:0] root_i,
        input  logic        sticky_i,
        input  roundMode_t  rm_i,
        output logic [23:0] sig_o,
        output logic        carry_o,
        output logic        inexact_o
);

        logic        lsb;
        logic        guard;
        logic        rnd;
        logic        roundUp;
        logic [24:0] sum;

        // Bits below the kept 24
        assign lsb   = root_i[2];
        assign guard = root_i[1];
        assign rnd   = root_i[0];

        assign inexact_o = guard | rnd | sticky_i;

        always_comb begin
                case (rm_i)
                        RTZ, RDN: roundUp = 1'b0;
                        RUP: roundUp = inexact_o;
                        // Ties away, guard alone decides
                        RMM: roundUp = guard;
                        // Nearest even, tie goes to an even lsb
                        default: roundUp = guard & (rnd | sticky_i | lsb);
                endcase
        end

        assign sum = {1'b0, root_i[25:2]} + 25'(roundUp);

        // All ones plus one, renormalize to 1.0
        assign carry_o = sum[24];
        assign sig_o   = carry_o ? sum[24:1] : sum[23:0];

endmodule

//--- hw/fpUnpack.sv
// Registers one request per strobe with no stall; reserved rounding codes are mapped to RNE
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpUnpack import fpuPkg::*; (
        input  logic        clk_i,
        input  logic        rst_i,
        input  logic        valid_i,
        input  logic [31:0] operand_i,
        input  roundMode_t  rm_i,
        output logic        opValid_o,
        output unpackedOp_t op_o
);

        logic [7:0]        expField;
        logic [22:0]       fracField;
        logic              expZero;
        logic              expOnes;
        logic              fracZero;
        fpClass_t          cls;
        logic [4:0]        lzCount;
        logic signed [9:0] unbiasedExp;
        logic [23:0]       normSig;
        roundMode_t        rmLegal;

        // Split the IEEE fields
        assign expField  = operand_i[30:23];
        assign fracField = operand_i[22:0];
        assign expZero   = (expField == 8'h00);
        assign expOnes   = (expField == 8'hff);
        assign fracZero  = (fracField == 23'd0);

        // Class decode, exactly one bit set
        always_comb begin
                cls           = '0;
                cls.zero      = expZero & fracZero;
                cls.subnormal = expZero & ~fracZero;
                cls.inf       = expOnes & fracZero;
                // Quiet bit is the top fraction bit
                cls.qNan      = expOnes & ~fracZero & fracField[22];
                cls.sNan      = expOnes & ~fracZero & ~fracField[22];
                cls.normal    = ~expZero & ~expOnes;
        end

        // Leading zeros of the fraction, the lowest set bit is overwritten by higher ones
        always_comb begin
                lzCount = 5'd0;
                for (int i = 0; i < 23; i++) begin
                        if (fracField[i]) begin
                                lzCount = 5'(22 - i);
                        end
                end
        end

        // Normalize subnormals so the leading one lands on bit 23
        always_comb begin
                if (expZero) begin
                        normSig     = {1'b0, fracField} << (lzCount + 5'd1);
                        // Value is frac * 2^-149, giving -127 minus the shift excess
                        unbiasedExp = -10'(`FP_BIAS) - $signed({5'd0, lzCount});
                end else begin
                        normSig     = {1'b1, fracField};
                        unbiasedExp = $signed({2'b00, expField}) - 10'(`FP_BIAS);
                end
        end

        // Reserved codes fall back to round-to-nearest-even
        always_comb begin
                case (rm_i)
                        RNE, RTZ, RDN, RUP, RMM: rmLegal = rm_i;
                        default: rmLegal = RNE;
                endcase
        end

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        opValid_o <= 1'b0;
                end else begin
                        opValid_o <= valid_i;
                end
        end

        // Payload only loads with a request
        always_ff @(posedge clk_i) begin
                if (valid_i) begin
                        op_o.raw <= operand_i;
                        op_o.cls <= cls;
                        op_o.exp <= unbiasedExp;
                        op_o.sig <= normSig;
                        op_o.rm  <= rmLegal;
                end
        end

endmodule

//--- hw/opFifo.sv
// Operand queue without back-pressure; a push into a full queue is lost and flagged a cycle later
`timescale 1ns/1ps
`include "fpu_consts.svh"

module opFifo import fpuPkg::*; (
        input  logic        clk_i,
        input  logic        rst_i,
        input  logic        push_i,
        input  logic        pop_i,
        input  unpackedOp_t data_i,
        output unpackedOp_t data_o,
        output logic        notEmpty_o,
        output logic        overflow_o
);

        localparam int ptrWidth = (`OPQ_DEPTH > 1) ? $clog2(`OPQ_DEPTH) : 1;
        localparam logic [ptrWidth-1:0] lastIdx = ptrWidth'(`OPQ_DEPTH - 1);

        unpackedOp_t         mem [`OPQ_DEPTH];
        logic [ptrWidth-1:0] rdPtr;
        logic [ptrWidth-1:0] wrPtr;
        logic [ptrWidth:0]   count;
        logic                full;
        logic                doPush;
        logic                doPop;

        assign full       = (count == (ptrWidth + 1)'(`OPQ_DEPTH));
        assign notEmpty_o = (count != '0);

        // Pop only counts with data present
        assign doPop  = pop_i & notEmpty_o;
        // A pop in the same cycle frees the slot for a push on a full queue
        assign doPush = push_i & (~full | doPop);

        // Head entry, read straight from storage
        assign data_o = mem[rdPtr];

        always_ff @(posedge clk_i) begin
                if (doPush) begin
                        mem[wrPtr] <= data_i;
                end
        end

        // Pointers wrap at the last entry
        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        rdPtr      <= '0;
                        wrPtr      <= '0;
                        count      <= '0;
                        overflow_o <= 1'b0;
                end else begin
                        if (doPush) begin
                                wrPtr <= (wrPtr == lastIdx) ? '0 : wrPtr + 1'b1;
                        end
                        if (doPop) begin
                                rdPtr <= (rdPtr == lastIdx) ? '0 : rdPtr + 1'b1;
                        end
                        // Occupancy only moves on an unbalanced push or pop
                        if (doPush && !doPop) begin
                                count <= count + 1'b1;
                        end else if (doPop && !doPush) begin
                                count <= count - 1'b1;
                        end
                        // Dropped request
                        overflow_o <= push_i & ~doPush;
                end
        end

endmodule

//--- hw/fpSqrtCore.sv
// One operation at a time; inputs must be normalized so the root is always a normal number
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpSqrtCore import fpuPkg::*; (
        input  logic        clk_i,
        input  logic        rst_i,
        input  logic        notEmpty_i,
        input  unpackedOp_t op_i,
        output logic        pop_o,
        output logic        done_o,
        output logic [31:0] result_o,
        output logic        nv_o,
        output logic        nx_o
);

        typedef enum logic [2:0] {sIdle, sSpec, sIter, sRound, sDone} state_t;

        state_t            state;
        logic [4:0]        iterCnt;
        // Remaining radicand bits, consumed two per step
        logic [25:0]       radicand;
        logic [27:0]       rem;
        logic [25:0]       root;
        logic [29:0]       acc;
        logic [29:0]       trial;
        logic [27:0]       remNext;
        logic [25:0]       rootNext;
        logic [25:0]       startRad;
        logic signed [9:0] rootExp;
        logic signed [9:0] biasedExp;
        roundMode_t        rmReg;
        logic              capSpecial;
        logic              capNv;
        logic [31:0]       capRes;
        logic              isSpecial;
        logic              nvReg;
        logic [31:0]       specRes;
        logic [23:0]       sigRnd;
        logic              carryRnd;
        logic              nxRnd;
        logic [23:0]       sigReg;
        logic              carryReg;
        logic              nxReg;

        // Take the head whenever idle
        assign pop_o = (state == sIdle) & notEmpty_i;

        // Special cases decided from the class of the head
        always_comb begin
                capSpecial = 1'b1;
                capNv      = 1'b0;
                capRes     = `FP_CANON_NAN;
                if (op_i.cls.qNan | op_i.cls.sNan) begin
                        capNv = op_i.cls.sNan;
                end else if (op_i.cls.zero) begin
                        // Signed zero passes through
                        capRes = op_i.raw;
                end else if (op_i.raw[31]) begin
                        capNv = 1'b1;
                end else if (op_i.cls.inf) begin
                        capRes = op_i.raw;
                end else begin
                        capSpecial = 1'b0;
                end
        end

        // Odd exponent keeps the significand doubled, even halves it back
        // Both place the root leading one at bit 25
        assign startRad = op_i.exp[0] ? {op_i.sig, 2'b00} : {1'b0, op_i.sig, 1'b0};

        // One restoring step
        assign acc   = {rem, radicand[25:24]};
        assign trial = acc - {2'b00, root, 2'b01};

        always_comb begin
                if (!trial[29]) begin
                        remNext  = trial[27:0];
                        rootNext = {root[24:0], 1'b1};
                end else begin
                        remNext  = acc[27:0];
                        rootNext = {root[24:0], 1'b0};
                end
        end

        // Sticky from whatever remainder is left
        fpRound i_round (
                .root_i    (root),
                .sticky_i  (|rem),
                .rm_i      (rmReg),
                .sig_o     (sigRnd),
                .carry_o   (carryRnd),
                .inexact_o (nxRnd)
        );

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        state   <= sIdle;
                        iterCnt <= '0;
                end else begin
                        case (state)
                                sIdle: begin
                                        iterCnt <= '0;
                                        if (pop_o) begin
                                                state <= capSpecial ? sSpec : sIter;
                                        end
                                end
                                // Special result waits one cycle to line up with done
                                sSpec: state <= sDone;
                                sIter: begin
                                        iterCnt <= iterCnt + 5'd1;
                                        if (iterCnt == 5'(`SQRT_ITERS - 1)) begin
                                                state <= sRound;
                                        end
                                end
                                sRound: state <= sDone;
                                default: state <= sIdle;
                        endcase
                end
        end

        // Datapath registers
        always_ff @(posedge clk_i) begin
                if (pop_o) begin
                        isSpecial <= capSpecial;
                        nvReg     <= capNv;
                        specRes   <= capRes;
                        // Floor of half the exponent
                        rootExp   <= $signed(op_i.exp) >>> 1;
                        rmReg     <= op_i.rm;
                        radicand  <= startRad;
                        rem       <= '0;
                        root      <= '0;
                end else if (state == sIter) begin
                        radicand <= {radicand[23:0], 2'b00};
                        rem      <= remNext;
                        root     <= rootNext;
                end
                if (state == sRound) begin
                        sigReg   <= sigRnd;
                        carryReg <= carryRnd;
                        nxReg    <= nxRnd;
                end
        end

        // Assembly, carry bumps the exponent
        assign biasedExp = rootExp + 10'(`FP_BIAS) + $signed({9'd0, carryReg});

        assign done_o   = (state == sDone);
        assign result_o = isSpecial ? specRes : {1'b0, biasedExp[7:0], sigReg[22:0]};
        assign nv_o     = done_o & nvReg;
        // Special results are always exact
        assign nx_o     = done_o & ~isSpecial & nxReg;

endmodule

//--- hw/fpSqrtUnit.sv
// FSQRT.S unit without back-pressure; results leave in order, requests beyond the queue are dropped
`timescale 1ns/1ps

module fpSqrtUnit import fpuPkg::*; (
        input  logic        clk_i,
        input  logic        rst_i,
        input  logic        valid_i,
        input  logic [31:0] operand_i,
        input  logic [2:0]  rm_i,
        output logic        done_o,
        output logic        nv_o,
        output logic        nx_o,
        output logic        overflow_o,
        output logic [31:0] result_o
);

        logic        opValid;
        unpackedOp_t op;
        unpackedOp_t head;
        logic        notEmpty;
        logic        pop;

        // Producer, one registered stage
        fpUnpack i_unpack (
                .clk_i     (clk_i),
                .rst_i     (rst_i),
                .valid_i   (valid_i),
                .operand_i (operand_i),
                .rm_i      (roundMode_t'(rm_i)),
                .opValid_o (opValid),
                .op_o      (op)
        );

        // Buffer between producer and core
        opFifo i_fifo (
                .clk_i      (clk_i),
                .rst_i      (rst_i),
                .push_i     (opValid),
                .pop_i      (pop),
                .data_i     (op),
                .data_o     (head),
                .notEmpty_o (notEmpty),
                .overflow_o (overflow_o)
        );

        // Consumer
        fpSqrtCore i_core (
                .clk_i      (clk_i),
                .rst_i      (rst_i),
                .notEmpty_i (notEmpty),
                .op_i       (head),
                .pop_o      (pop),
                .done_o     (done_o),
                .result_o   (result_o),
                .nv_o       (nv_o),
                .nx_o       (nx_o)
        );

endmodule

//--- test/fpSqrtUnit_assertions.sv
// Protocol checks bound into fpSqrtUnit; dropped requests stay counted, so the done_o bound is loose
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpSqrtUnit_assertions (
        input logic clk_i,
        input logic rst_i,
        input logic valid_i,
        input logic push_i,
        input logic pop_i,
        input logic done_i,
        input logic nv_i,
        input logic nx_i,
        input logic overflow_i
);

        // Requests seen minus results returned
        int   pending;
        // Queue occupancy rebuilt from its push and pop strobes
        int   level;
        logic pushOk;

        // A full queue only takes a push when the head leaves in the same cycle
        assign pushOk = push_i && (level < `OPQ_DEPTH || pop_i);

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        pending <= 0;
                        level   <= 0;
                end else begin
                        pending <= pending + (valid_i ? 1 : 0) - (done_i ? 1 : 0);
                        level   <= level + (pushOk ? 1 : 0) - (pop_i ? 1 : 0);
                end
        end

        // Result strobe lasts one cycle
        doneSingle: assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
                else $error("done_o stayed high for two cycles");

        // Core only takes from a filled queue
        popNonEmpty: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> level > 0)
                else $error("pop raised while the queue was empty");

        doneHasRequest: assert property (@(posedge clk_i) disable iff (rst_i) done_i |-> pending > 0)
                else $error("done_o without an earlier valid_i");

        // Registered outputs clear on the reset edge
        quietReset: assert property (@(posedge clk_i)
                        rst_i |=> !done_i && !nv_i && !nx_i && !overflow_i)
                else $error("outputs active right after a reset cycle");

endmodule

bind fpSqrtUnit fpSqrtUnit_assertions i_assertions (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (valid_i),
        .push_i     (opValid),
        .pop_i      (pop),
        .done_i     (done_o),
        .nv_i       (nv_o),
        .nx_i       (nx_o),
        .overflow_i (overflow_o)
);

//--- test/tb_fpSqrtUnit.sv
// Self-checking bench; the drop model assumes 2 busy core cycles per special operand and 28 per normal one
`timescale 1ns/1ps
`include "fpu_consts.svh"

module tb_fpSqrtUnit import fpuPkg::*; ();

        // Operation budget times the slowest idle latency, plus reset and drain slack
        localparam int maxCycles = 200 * 40 + 1000;

        typedef struct packed {
                logic [31:0] opnd;
                logic [31:0] res;
                logic        nv;
                logic        nx;
                // Core cycles from pop until idle again
                int          busy;
                // Required valid_i to done_o distance, zero when not checked
                int          lat;
                int          issue;
        } expRec_t;

        logic        clk_i;
        logic        rst_i;
        logic        valid_i;
        logic [31:0] operand_i;
        logic [2:0]  rm_i;
        logic        done_o;
        logic        nv_o;
        logic        nx_o;
        logic        overflow_o;
        logic [31:0] result_o;

        int          cycleCnt;
        int          valErrs;
        int          latErrs;
        int          ovfErrs;
        int          protErrs;
        // Accepted requests still waiting for done_o
        expRec_t     expQ[$];
        expRec_t     curRec;
        expRec_t     pendRec;
        logic        pendValid;
        // Shadow of the DUT queue, busy time of each held entry
        int          modelQ[$];
        int          coreBusy;
        logic        expOvf;

        fpSqrtUnit i_dut (
                .clk_i      (clk_i),
                .rst_i      (rst_i),
                .valid_i    (valid_i),
                .operand_i  (operand_i),
                .rm_i       (rm_i),
                .done_o     (done_o),
                .nv_o       (nv_o),
                .nx_o       (nx_o),
                .overflow_o (overflow_o),
                .result_o   (result_o)
        );

        initial begin
                clk_i = 1'b0;
                forever #10 clk_i = ~clk_i;
        end

        always @(posedge clk_i) begin
                cycleCnt <= cycleCnt + 1;
        end

        // Special cases per the NaN, zero, sign and infinity rules
        function automatic bit isSpecialOp(input logic [31:0] x);
                return (x[30:23] == 8'hff) || (x[30:0] == 31'd0) || x[31];
        endfunction

        // Expected {result, nv, nx}
        function automatic logic [33:0] sqrtRef(input logic [31:0] x, input logic [2:0] rm);
                logic [7:0]  ex;
                logic [22:0] fr;
                longint      n;
                longint      q;
                longint      r;
                longint      t;
                int          e;
                int          k;
                int          bexp;
                logic        up;
                ex = x[30:23];
                fr = x[22:0];
                if (ex == 8'hff && fr != 23'd0) begin
                        return {`FP_CANON_NAN, ~fr[22], 1'b0};
                end
                if (x[30:0] == 31'd0) begin
                        return {x, 2'b00};
                end
                if (x[31]) begin
                        return {`FP_CANON_NAN, 2'b10};
                end
                if (ex == 8'hff) begin
                        return {x, 2'b00};
                end
                // Operand value is n * 2^e
                if (ex == 8'h00) begin
                        n = fr;
                        e = -149;
                end else begin
                        n = {1'b1, fr};
                        e = ex;
                        e = e - 150;
                end
                // Even exponent so it halves exactly
                if (e % 2 != 0) begin
                        n = n << 1;
                        e = e - 1;
                end
                // Scale by 4^k until the integer root has 24 bits
                k = 0;
                while (n < (longint'(1) << 46)) begin
                        n = n << 2;
                        k++;
                end
                q = 0;
                for (int i = 23; i >= 0; i--) begin
                        t = q | (longint'(1) << i);
                        if (t * t <= n) begin
                                q = t;
                        end
                end
                r = n - q * q;
                // Exact half cannot occur, so both nearest modes round up when r > q
                case (rm)
                        3'd1, 3'd2: up = 1'b0;
                        3'd3: up = (r != 0);
                        default: up = (r > q);
                endcase
                q = q + longint'(up);
                bexp = e / 2 - k + 23 + `FP_BIAS;
                if (q == (longint'(1) << 24)) begin
                        q = q >> 1;
                        bexp++;
                end
                return {1'b0, bexp[7:0], q[22:0], 1'b0, r != 0};
        endfunction

        function automatic logic [31:0] randNormal();
                return {1'b0, 8'(1 + $urandom_range(253)), 23'($urandom)};
        endfunction

        // Raise valid_i for one cycle and stage the expected record
        task automatic sendRequest(input logic [31:0] x, input logic [2:0] rm, input bit chkLat);
                logic [33:0] want;
                @(posedge clk_i);
                #2;
                want         = sqrtRef(x, rm);
                curRec.opnd  = x;
                curRec.res   = want[33:2];
                curRec.nv    = want[1];
                curRec.nx    = want[0];
                curRec.busy  = isSpecialOp(x) ? 2 : 28;
                // Idle unit latency, 4 cycles special and 30 normal
                curRec.lat   = !chkLat ? 0 : (isSpecialOp(x) ? 4 : 30);
                curRec.issue = cycleCnt;
                valid_i      = 1'b1;
                operand_i    = x;
                rm_i         = rm;
        endtask

        task automatic idleInputs();
                @(posedge clk_i);
                #2;
                valid_i = 1'b0;
        endtask

        // Until every accepted request has returned
        task automatic waitIdle();
                @(negedge clk_i);
                while (expQ.size() != 0 || pendValid) begin
                        @(negedge clk_i);
                end
                repeat (2) @(posedge clk_i);
        endtask

        task automatic runOne(input logic [31:0] x, input logic [2:0] rm);
                sendRequest(x, rm, 1'b1);
                idleInputs();
                waitIdle();
        endtask

        // Queue occupancy and core busy time, evaluated mid-cycle
        always @(negedge clk_i) begin : occupancyModel
                logic mPop;
                logic mPush;
                if (rst_i) begin
                        modelQ.delete();
                        expQ.delete();
                        coreBusy  = 0;
                        pendValid = 1'b0;
                        expOvf    = 1'b0;
                end else begin
                        // Flag for a push one cycle back
                        assert (overflow_o === expOvf) else begin
                                ovfErrs++;
                                $display("ERR %0t overflow_o expected %b got %b",
                                         $time, expOvf, overflow_o);
                        end
                        mPop   = (coreBusy == 0) && (modelQ.size() != 0);
                        // Pop in the same cycle makes room on a full queue
                        mPush  = pendValid && (modelQ.size() < `OPQ_DEPTH || mPop);
                        expOvf = pendValid && !mPush;
                        if (mPop) begin
                                coreBusy = modelQ.pop_front();
                        end else if (coreBusy > 0) begin
                                coreBusy--;
                        end
                        if (mPush) begin
                                modelQ.push_back(pendRec.busy);
                                expQ.push_back(pendRec);
                        end
                        pendValid = valid_i;
                        pendRec   = curRec;
                end
        end

        always @(negedge clk_i) begin : compareResults
                expRec_t rec;
                if (!rst_i && done_o) begin
                        if (expQ.size() == 0) begin
                                protErrs++;
                                $display("done_o pulsed at %0t with no request outstanding", $time);
                        end else begin
                                rec = expQ.pop_front();
                                assert (result_o === rec.res) else begin
                                        valErrs++;
                                        $display("ERR %0t result_o expected %h got %h (operand %h)",
                                                 $time, rec.res, result_o, rec.opnd);
                                end
                                assert (nv_o === rec.nv) else begin
                                        valErrs++;
                                        $display("ERR %0t nv_o expected %b got %b (operand %h)",
                                                 $time, rec.nv, nv_o, rec.opnd);
                                end
                                assert (nx_o === rec.nx) else begin
                                        valErrs++;
                                        $display("ERR %0t nx_o expected %b got %b (operand %h)",
                                                 $time, rec.nx, nx_o, rec.opnd);
                                end
                                if (rec.lat != 0) begin
                                        assert (cycleCnt - rec.issue == rec.lat) else begin
                                                latErrs++;
                                                $display("Operand %h took %0d cycles instead of %0d",
                                                         rec.opnd, cycleCnt - rec.issue, rec.lat);
                                        end
                                end
                        end
                end
        end

        initial begin : watchdog
                while (cycleCnt < maxCycles) begin
                        @(posedge clk_i);
                end
                $display("Run stopped after %0d cycles without finishing the tests", maxCycles);
                $display("Testbench failed");
                $finish;
        end

        initial begin
                rst_i     = 1'b1;
                valid_i   = 1'b0;
                operand_i = 32'd0;
                rm_i      = 3'd0;
                cycleCnt  = 0;
                valErrs   = 0;
                latErrs   = 0;
                ovfErrs   = 0;
                protErrs  = 0;
                void'($urandom(32'h6342e4e3));
                repeat (8) @(posedge clk_i);
                #2;
                rst_i = 1'b0;

                // Signed zeros, infinities, NaNs, negatives
                runOne(32'h00000000, RNE);
                runOne(32'h80000000, RNE);
                runOne(32'h7f800000, RNE);
                runOne(32'hff800000, RNE);
                runOne(32'h7fc00001, RNE);
                runOne(32'h7f800001, RNE);
                runOne(32'hffc00000, RNE);
                runOne(32'hbf800000, RNE);
                runOne(32'h80000001, RNE);

                // Perfect squares under round-up, nx must stay low
                runOne(32'h40800000, RUP);
                runOne(32'h40100000, RUP);
                runOne(32'h3e800000, RUP);
                runOne(32'h3f800000, RUP);
                runOne(32'h41c80000, RUP);

                // Random normals, five modes then the reserved codes
                for (int m = 0; m < 8; m++) begin
                        for (int i = 0; i < ((m < 5) ? 20 : 4); i++) begin
                                runOne(randNormal(), 3'(m));
                        end
                end

                // Subnormals, smallest and largest first
                runOne(32'h00000001, RNE);
                runOne(32'h007fffff, RUP);
                runOne(32'h00400000, RTZ);
                runOne(32'h00000003, RMM);
                runOne(32'h00012345, RDN);
                for (int i = 0; i < 5; i++) begin
                        runOne({9'd0, 23'($urandom_range(32'h7fffff, 1))}, 3'($urandom_range(4)));
                end

                // Back-to-back burst, longer than queue plus core
                for (int i = 0; i < 14; i++) begin
                        if (i % 4 == 3) begin
                                sendRequest((i % 8 == 3) ? 32'h00000000 : 32'hc0000000,
                                            3'($urandom_range(4)), 1'b0);
                        end else begin
                                sendRequest(randNormal(), 3'($urandom_range(4)), 1'b0);
                        end
                end
                idleInputs();
                waitIdle();

                $display("Errors: value %0d, latency %0d, overflow %0d, protocol %0d",
                         valErrs, latErrs, ovfErrs, protErrs);
                if (valErrs + latErrs + ovfErrs + protErrs == 0) begin
                        $display("Testbench passed");
                end else begin
                        $display("Testbench failed");
                end
                $finish;
        end

endmodule

//--- sim.f
+incdir+hw
hw/fpuPkg.sv
hw/fpRound.sv
hw/fpUnpack.sv
hw/opFifo.sv
hw/fpSqrtCore.sv
hw/fpSqrtUnit.sv
test/fpSqrtUnit_assertions.sv
test/tb_fpSqrtUnit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fpSqrtUnit
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Testbench failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
